//--- hdl/cluster_periph_pkg.sv
`default_nettype none

package cluster_periph_pkg;

  // Crossbar size: cores 0 and 1, master peripheral 2
  localparam int unsigned NB_INITIATORS = 3;
  localparam int unsigned NB_TARGETS    = 4;

  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned BE_WIDTH   = DATA_WIDTH / 8;

  localparam int unsigned IDX_WIDTH      = $clog2(NB_TARGETS);
  localparam int unsigned INIT_IDX_WIDTH = $clog2(NB_INITIATORS);

  // Address map of the peripheral segment
  localparam logic [7:0] CLUSTER_BASE  = 8'h10;
  localparam logic [3:0] PERIPH_SEG_LO = 4'h2;
  localparam logic [3:0] PERIPH_SEG_HI = 4'h3;
  localparam int unsigned ROUTING_LSB  = 16;
  localparam int unsigned ROUTING_MSB  = 17;

  // Everything outside the segment goes to the last port
  localparam int unsigned EXT_TARGET_IDX = NB_TARGETS - 1;

  typedef logic [ADDR_WIDTH-1:0]     periph_addr_t;
  typedef logic [DATA_WIDTH-1:0]     periph_data_t;
  typedef logic [IDX_WIDTH-1:0]      periph_idx_t;
  typedef logic [INIT_IDX_WIDTH-1:0] periph_init_idx_t;
  typedef logic [NB_INITIATORS-1:0]  periph_id_t;

  typedef struct packed {
    periph_addr_t        addr;
    periph_data_t        data;
    periph_id_t          id;
    logic                we_n;
    logic [BE_WIDTH-1:0] be;
  } periph_req_t;

  typedef struct packed {
    periph_data_t data;
    periph_id_t   id;
    logic         opc;
  } periph_resp_t;

endpackage

`default_nettype wire

//--- hdl/periph_req_if.sv
`timescale 1ns/100ps
`default_nettype none

interface periph_req_if;

  // All arrays are indexed by initiator
  logic [cluster_periph_pkg::NB_INITIATORS-1:0] req;
  cluster_periph_pkg::periph_idx_t [cluster_periph_pkg::NB_INITIATORS-1:0] tgt_idx;
  cluster_periph_pkg::periph_req_t [cluster_periph_pkg::NB_INITIATORS-1:0] payload;
  logic [cluster_periph_pkg::NB_INITIATORS-1:0] gnt;

  modport decoder (
    output req,
    output tgt_idx,
    output payload
  );

  modport arbiter (
    input  req,
    input  tgt_idx,
    input  payload,
    output gnt
  );

endinterface

`default_nettype wire

//--- hdl/periph_addr_decode.sv
`timescale 1ns/100ps
`default_nettype none

module periph_addr_decode (
  input  logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_req_i,
  input  cluster_periph_pkg::periph_addr_t [cluster_periph_pkg::NB_INITIATORS-1:0]
         init_addr_i,
  input  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0]
         init_wdata_i,
  input  logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_we_n_i,
  input  logic [cluster_periph_pkg::NB_INITIATORS-1:0][cluster_periph_pkg::BE_WIDTH-1:0]
         init_be_i,
  periph_req_if.decoder req_o
);

  function automatic cluster_periph_pkg::periph_idx_t decode_target(
    input cluster_periph_pkg::periph_addr_t addr
  );
    logic in_cluster;
    logic in_segment;
    in_cluster = (addr[31:24] == cluster_periph_pkg::CLUSTER_BASE);
    in_segment = (addr[23:20] >= cluster_periph_pkg::PERIPH_SEG_LO) &&
                 (addr[23:20] <= cluster_periph_pkg::PERIPH_SEG_HI);
    if (in_cluster && in_segment) begin
      return addr[cluster_periph_pkg::ROUTING_MSB:cluster_periph_pkg::ROUTING_LSB];
    end else begin
      // Outside the peripheral segment
      return cluster_periph_pkg::periph_idx_t'(cluster_periph_pkg::EXT_TARGET_IDX);
    end
  endfunction

  for (genvar i = 0; i < cluster_periph_pkg::NB_INITIATORS; i++) begin : gen_init
    assign req_o.req[i]          = init_req_i[i];
    assign req_o.tgt_idx[i]      = decode_target(init_addr_i[i]);
    assign req_o.payload[i].addr = init_addr_i[i];
    assign req_o.payload[i].data = init_wdata_i[i];
    // One-hot tag so the response can find its way back
    assign req_o.payload[i].id   = cluster_periph_pkg::periph_id_t'(1) << i;
    assign req_o.payload[i].we_n = init_we_n_i[i];
    assign req_o.payload[i].be   = init_be_i[i];
  end

endmodule

`default_nettype wire

//--- hdl/periph_rr_arbiter.sv
`timescale 1ns/100ps
`default_nettype none

module periph_rr_arbiter (
  input  logic clk_i,
  input  logic reset_i,
  periph_req_if.arbiter req_i,
  output logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_req_o,
  output cluster_periph_pkg::periph_req_t [cluster_periph_pkg::NB_TARGETS-1:0]
         tgt_payload_o,
  input  logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_gnt_i
);

  logic [cluster_periph_pkg::NB_TARGETS-1:0] found;
  cluster_periph_pkg::periph_init_idx_t [cluster_periph_pkg::NB_TARGETS-1:0] sel_idx;
  cluster_periph_pkg::periph_init_idx_t [cluster_periph_pkg::NB_TARGETS-1:0] rr_ptr;

  // Per target, first requesting initiator at or after the pointer
  always_comb begin
    int unsigned pos;
    found   = '0;
    sel_idx = '0;
    for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
      for (int k = 0; k < cluster_periph_pkg::NB_INITIATORS; k++) begin
        pos = (int'(rr_ptr[t]) + k) % cluster_periph_pkg::NB_INITIATORS;
        if (!found[t] && req_i.req[pos] &&
            req_i.tgt_idx[pos] == cluster_periph_pkg::periph_idx_t'(t)) begin
          found[t]   = 1'b1;
          sel_idx[t] = cluster_periph_pkg::periph_init_idx_t'(pos);
        end
      end
    end
  end

  always_comb begin
    req_i.gnt = '0;
    for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
      tgt_req_o[t]     = found[t];
      tgt_payload_o[t] = req_i.payload[sel_idx[t]];
      // Grant goes back to the winner only
      if (found[t] && tgt_gnt_i[t]) begin
        req_i.gnt[sel_idx[t]] = 1'b1;
      end
    end
  end

  // Pointer moves past the winner once the handshake completes
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr <= '0;
    end else begin
      for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
        if (found[t] && tgt_gnt_i[t]) begin
          if (sel_idx[t] == cluster_periph_pkg::periph_init_idx_t'(
                cluster_periph_pkg::NB_INITIATORS - 1)) begin
            rr_ptr[t] <= '0;
          end else begin
            rr_ptr[t] <= sel_idx[t] + 1'b1;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/periph_resp_router.sv
`timescale 1ns/100ps
`default_nettype none

module periph_resp_router (
  input  logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_rvalid_i,
  input  cluster_periph_pkg::periph_resp_t [cluster_periph_pkg::NB_TARGETS-1:0]
         tgt_resp_i,
  output logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_rvalid_o,
  output cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0]
         init_rdata_o,
  output logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_opc_o
);

  always_comb begin
    cluster_periph_pkg::periph_id_t own_id;
    init_rvalid_o = '0;
    init_rdata_o  = '0;
    init_opc_o    = '0;
    for (int i = 0; i < cluster_periph_pkg::NB_INITIATORS; i++) begin
      own_id = cluster_periph_pkg::periph_id_t'(1) << i;
      // Walk downwards so the lowest matching target wins
      for (int t = cluster_periph_pkg::NB_TARGETS - 1; t >= 0; t--) begin
        if (tgt_rvalid_i[t] && tgt_resp_i[t].id == own_id) begin
          init_rvalid_o[i] = 1'b1;
          init_rdata_o[i]  = tgt_resp_i[t].data;
          init_opc_o[i]    = tgt_resp_i[t].opc;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/cluster_periph_xbar.sv
`timescale 1ns/100ps
`default_nettype none

module cluster_periph_xbar (
  input  logic clk_i,
  input  logic reset_i,

  // Initiator side
  input  logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_req_i,
  input  cluster_periph_pkg::periph_addr_t [cluster_periph_pkg::NB_INITIATORS-1:0]
         init_addr_i,
  input  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0]
         init_wdata_i,
  input  logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_we_n_i,
  input  logic [cluster_periph_pkg::NB_INITIATORS-1:0][cluster_periph_pkg::BE_WIDTH-1:0]
         init_be_i,
  output logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_gnt_o,
  output logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_rvalid_o,
  output cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0]
         init_rdata_o,
  output logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_opc_o,

  // Target side
  output logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_req_o,
  output cluster_periph_pkg::periph_addr_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_addr_o,
  output cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_wdata_o,
  output cluster_periph_pkg::periph_id_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_id_o,
  output logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_we_n_o,
  output logic [cluster_periph_pkg::NB_TARGETS-1:0][cluster_periph_pkg::BE_WIDTH-1:0]
         tgt_be_o,
  input  logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_gnt_i,
  input  logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_rvalid_i,
  input  cluster_periph_pkg::periph_id_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_rid_i,
  input  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_rdata_i,
  input  logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_opc_i
);

  cluster_periph_pkg::periph_req_t  [cluster_periph_pkg::NB_TARGETS-1:0] tgt_payload;
  cluster_periph_pkg::periph_resp_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_resp;

  periph_req_if req_bus ();

  periph_addr_decode i_decode (
    .init_req_i   (init_req_i),
    .init_addr_i  (init_addr_i),
    .init_wdata_i (init_wdata_i),
    .init_we_n_i  (init_we_n_i),
    .init_be_i    (init_be_i),
    .req_o        (req_bus.decoder)
  );

  periph_rr_arbiter i_arbiter (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .req_i         (req_bus.arbiter),
    .tgt_req_o     (tgt_req_o),
    .tgt_payload_o (tgt_payload),
    .tgt_gnt_i     (tgt_gnt_i)
  );

  // Grant is already steered to the winning initiator
  assign init_gnt_o = req_bus.gnt;

  for (genvar t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin : gen_tgt_bind
    assign tgt_addr_o[t]  = tgt_payload[t].addr;
    assign tgt_wdata_o[t] = tgt_payload[t].data;
    assign tgt_id_o[t]    = tgt_payload[t].id;
    assign tgt_we_n_o[t]  = tgt_payload[t].we_n;
    assign tgt_be_o[t]    = tgt_payload[t].be;
    assign tgt_resp[t]    = '{data: tgt_rdata_i[t], id: tgt_rid_i[t], opc: tgt_opc_i[t]};
  end

  periph_resp_router i_router (
    .tgt_rvalid_i  (tgt_rvalid_i),
    .tgt_resp_i    (tgt_resp),
    .init_rvalid_o (init_rvalid_o),
    .init_rdata_o  (init_rdata_o),
    .init_opc_o    (init_opc_o)
  );

endmodule

`default_nettype wire

//--- test/tb_clock_gen.sv
`timescale 1ns/100ps
`default_nettype none

module tb_clock_gen (
  output logic clk_o,
  output logic reset_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for 5 cycles, released on a falling edge
  initial begin
    reset_o = 1'b1;
    repeat (5) @(posedge clk_o);
    @(negedge clk_o);
    reset_o = 1'b0;
  end

endmodule

`default_nettype wire

//--- test/tb_cluster_periph_xbar.sv
`timescale 1ns/100ps
`default_nettype none

module tb_cluster_periph_xbar;

  logic clk;
  logic reset;

  logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_req, init_we_n, init_gnt;
  logic [cluster_periph_pkg::NB_INITIATORS-1:0] init_rvalid, init_opc;
  cluster_periph_pkg::periph_addr_t [cluster_periph_pkg::NB_INITIATORS-1:0] init_addr;
  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0] init_wdata;
  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0] init_rdata;
  logic [cluster_periph_pkg::NB_INITIATORS-1:0][cluster_periph_pkg::BE_WIDTH-1:0] init_be;

  logic [cluster_periph_pkg::NB_TARGETS-1:0] tgt_req, tgt_we_n, tgt_gnt, tgt_rvalid, tgt_opc;
  cluster_periph_pkg::periph_addr_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_addr;
  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_wdata, tgt_rdata;
  cluster_periph_pkg::periph_id_t [cluster_periph_pkg::NB_TARGETS-1:0] tgt_id, tgt_rid;
  logic [cluster_periph_pkg::NB_TARGETS-1:0][cluster_periph_pkg::BE_WIDTH-1:0] tgt_be;

  // Room for 32 lines of 7 words
  logic [31:0] tdata [0:223];

  // Initiator models
  logic [cluster_periph_pkg::NB_INITIATORS-1:0] pend, wait_resp, stim_we_n;
  cluster_periph_pkg::periph_addr_t [cluster_periph_pkg::NB_INITIATORS-1:0] stim_addr;
  cluster_periph_pkg::periph_data_t [cluster_periph_pkg::NB_INITIATORS-1:0] stim_wdata;
  logic [cluster_periph_pkg::NB_INITIATORS-1:0][cluster_periph_pkg::BE_WIDTH-1:0] stim_be;
  cluster_periph_pkg::periph_idx_t exp_tgt [cluster_periph_pkg::NB_INITIATORS];
  cluster_periph_pkg::periph_data_t exp_rdata [cluster_periph_pkg::NB_INITIATORS];

  // Target models
  int gnt_delay [cluster_periph_pkg::NB_TARGETS];
  int req_age [cluster_periph_pkg::NB_TARGETS];
  int rr_next [cluster_periph_pkg::NB_TARGETS];
  int owner_next [cluster_periph_pkg::NB_TARGETS];
  int owner [cluster_periph_pkg::NB_TARGETS];
  logic [cluster_periph_pkg::NB_TARGETS-1:0] resp_next;
  cluster_periph_pkg::periph_id_t resp_id [cluster_periph_pkg::NB_TARGETS];
  cluster_periph_pkg::periph_data_t resp_data [cluster_periph_pkg::NB_TARGETS];

  tb_clock_gen i_clock_gen (.clk_o(clk), .reset_o(reset));

  cluster_periph_xbar DUT (
    .clk_i (clk), .reset_i (reset),
    .init_req_i (init_req), .init_addr_i (init_addr), .init_wdata_i (init_wdata),
    .init_we_n_i (init_we_n), .init_be_i (init_be), .init_gnt_o (init_gnt),
    .init_rvalid_o (init_rvalid), .init_rdata_o (init_rdata), .init_opc_o (init_opc),
    .tgt_req_o (tgt_req), .tgt_addr_o (tgt_addr), .tgt_wdata_o (tgt_wdata),
    .tgt_id_o (tgt_id), .tgt_we_n_o (tgt_we_n), .tgt_be_o (tgt_be), .tgt_gnt_i (tgt_gnt),
    .tgt_rvalid_i (tgt_rvalid), .tgt_rid_i (tgt_rid), .tgt_rdata_i (tgt_rdata),
    .tgt_opc_i (tgt_opc)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_idx(input cluster_periph_pkg::periph_idx_t got,
                           input cluster_periph_pkg::periph_idx_t exp);
    if (got !== exp)
      abort_run($sformatf("Error at %0t: request seen at target %0d, expected %0d",
                          $time, got, exp));
  endtask

  task automatic check_req(input cluster_periph_pkg::periph_req_t got,
                           input cluster_periph_pkg::periph_req_t exp);
    if (got !== exp)
      abort_run($sformatf("Error at %0t: request payload %h, expected %h", $time, got, exp));
  endtask

  task automatic check_resp(input cluster_periph_pkg::periph_resp_t got,
                            input cluster_periph_pkg::periph_resp_t exp);
    if (got !== exp)
      abort_run($sformatf("Error at %0t: response %h, expected %h", $time, got, exp));
  endtask

  task automatic check_id(input cluster_periph_pkg::periph_id_t got,
                          input cluster_periph_pkg::periph_id_t exp, input string what);
    if (got !== exp)
      abort_run($sformatf("Error at %0t: %s is %b, expected %b", $time, what, got, exp));
  endtask

  function automatic int id_to_index(input cluster_periph_pkg::periph_id_t id);
    int idx;
    idx = -1;
    for (int i = 0; i < cluster_periph_pkg::NB_INITIATORS; i++) begin
      if (id == (cluster_periph_pkg::periph_id_t'(1) << i)) idx = i;
    end
    return idx;
  endfunction

  // Round robin: first pending initiator for this target at or after the pointer
  function automatic int next_winner(input int t);
    int pos;
    for (int k = 0; k < cluster_periph_pkg::NB_INITIATORS; k++) begin
      pos = (rr_next[t] + k) % cluster_periph_pkg::NB_INITIATORS;
      if (pend[pos] && exp_tgt[pos] == cluster_periph_pkg::periph_idx_t'(t)) return pos;
    end
    return -1;
  endfunction

  task automatic load_line(input int n);
    int i;
    i = int'(tdata[n*7+1]);
    if (i < 0 || i >= cluster_periph_pkg::NB_INITIATORS)
      abort_run($sformatf("Bad initiator number %0d in line %0d of the data file", i, n));
    stim_addr[i] = tdata[n*7+2];
    stim_wdata[i] = tdata[n*7+3];
    stim_we_n[i] = tdata[n*7+4][0];
    stim_be[i] = {cluster_periph_pkg::BE_WIDTH{1'b1}} >> (n % cluster_periph_pkg::BE_WIDTH);
    exp_tgt[i] = cluster_periph_pkg::periph_idx_t'(tdata[n*7+5]);
    exp_rdata[i] = tdata[n*7+6];
    pend[i] = 1'b1;
    wait_resp[i] = 1'b1;
  endtask

  task automatic drive_inputs();
    init_req = pend;
    init_addr = stim_addr;
    init_wdata = stim_wdata;
    init_we_n = stim_we_n;
    init_be = stim_be;
    for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
      tgt_gnt[t] = (req_age[t] >= gnt_delay[t]);
      tgt_rvalid[t] = resp_next[t];
      tgt_rid[t] = resp_id[t];
      tgt_rdata[t] = resp_data[t];
      owner[t] = owner_next[t];
    end
    resp_next = '0;
  endtask

  task automatic sample_outputs();
    cluster_periph_pkg::periph_id_t exp_gnt;
    cluster_periph_pkg::periph_id_t exp_rvalid;
    cluster_periph_pkg::periph_id_t own_id;
    cluster_periph_pkg::periph_req_t got_req;
    cluster_periph_pkg::periph_req_t exp_req;
    cluster_periph_pkg::periph_resp_t got_resp;
    cluster_periph_pkg::periph_resp_t exp_resp;
    int obs;
    int w;
    exp_gnt = '0;
    exp_rvalid = '0;
    for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
      if (tgt_rvalid[t]) exp_rvalid[owner[t]] = 1'b1;
    end
    check_id(init_rvalid, exp_rvalid, "init_rvalid_o");
    for (int i = 0; i < cluster_periph_pkg::NB_INITIATORS; i++) begin
      if (exp_rvalid[i]) begin
        own_id = cluster_periph_pkg::periph_id_t'(1) << i;
        got_resp = '{data: init_rdata[i], id: init_rvalid & own_id, opc: init_opc[i]};
        exp_resp = '{data: exp_rdata[i], id: own_id, opc: 1'b0};
        check_resp(got_resp, exp_resp);
        wait_resp[i] = 1'b0;
      end
    end
    for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
      if (tgt_req[t] && tgt_gnt[t]) begin
        obs = id_to_index(tgt_id[t]);
        if (obs < 0 || !pend[obs])
          abort_run($sformatf("Error at %0t: target %0d accepted a request with unknown id %b",
                              $time, t, tgt_id[t]));
        check_idx(cluster_periph_pkg::periph_idx_t'(t), exp_tgt[obs]);
        w = next_winner(t);
        exp_req = '{addr: stim_addr[w], data: stim_wdata[w],
                    id: cluster_periph_pkg::periph_id_t'(1) << w,
                    we_n: stim_we_n[w], be: stim_be[w]};
        got_req = '{addr: tgt_addr[t], data: tgt_wdata[t], id: tgt_id[t],
                    we_n: tgt_we_n[t], be: tgt_be[t]};
        check_req(got_req, exp_req);
        exp_gnt[w] = 1'b1;
        pend[w] = 1'b0;
        rr_next[t] = (w + 1) % cluster_periph_pkg::NB_INITIATORS;
        // Response goes out one cycle after the grant
        resp_next[t] = 1'b1;
        resp_id[t] = tgt_id[t];
        resp_data[t] = tgt_addr[t] ^ cluster_periph_pkg::periph_data_t'(t);
        owner_next[t] = w;
        req_age[t] = 0;
        gnt_delay[t] = $urandom % 4;
      end else if (tgt_req[t]) begin
        req_age[t]++;
      end
    end
    check_id(init_gnt, exp_gnt, "init_gnt_o");
  endtask

  task automatic wait_reset_release();
    int cyc;
    cyc = 0;
    while (reset !== 1'b0) begin
      if (cyc == 200) abort_run("Timeout: reset was never released");
      @(posedge clk);
      cyc++;
    end
  endtask

  task automatic run_group(input logic [31:0] grp);
    int cyc;
    cyc = 0;
    while (pend != '0 || wait_resp != '0) begin
      if (cyc == 200)
        abort_run($sformatf("Timeout: group %0d did not finish its grants and responses", grp));
      @(negedge clk);
      drive_inputs();
      // Outputs have settled and the handshake completes at the next rising edge
      #1;
      sample_outputs();
      cyc++;
    end
  endtask

  initial begin
    int n;
    logic [31:0] grp;
    void'($urandom(32'hfd4c));
    init_req = '0;
    init_addr = '0;
    init_wdata = '0;
    init_we_n = '1;
    init_be = '0;
    tgt_gnt = '0;
    tgt_rvalid = '0;
    tgt_rid = '0;
    tgt_rdata = '0;
    tgt_opc = '0;
    pend = '0;
    wait_resp = '0;
    resp_next = '0;
    stim_addr = '0;
    stim_wdata = '0;
    stim_we_n = '1;
    stim_be = '0;
    for (int t = 0; t < cluster_periph_pkg::NB_TARGETS; t++) begin
      gnt_delay[t] = $urandom % 4;
      req_age[t] = 0;
      rr_next[t] = 0;
      owner_next[t] = 0;
      owner[t] = 0;
      resp_id[t] = '0;
      resp_data[t] = '0;
    end
    for (int k = 0; k < 224; k++) tdata[k] = '1;
    $readmemh("test/periph_testdata.txt", tdata);
    wait_reset_release();
    n = 0;
    while (n < 32 && tdata[n*7] != '1) begin
      grp = tdata[n*7];
      // Lines of one group are issued together
      while (n < 32 && tdata[n*7] == grp) begin
        load_line(n);
        n++;
      end
      run_group(grp);
    end
    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- test/periph_testdata.txt
// group initiator address wdata we_n target rdata (all hex)
// rdata is the address XOR the target index
0 0 10210000 00000000 1 1 10210001
1 1 20000040 00000000 1 3 20000043
2 2 10400000 00000000 1 3 10400003
3 0 10120000 00000000 1 3 10120003
4 1 10320008 cafe0001 0 2 1032000a
5 2 10230004 12345678 0 3 10230007
6 0 10200010 00000000 1 0 10200010
6 1 10300020 00000000 1 0 10300020
7 0 10300100 00000000 1 0 10300100
7 2 10200200 a5a5a5a5 0 0 10200200
8 0 10220004 00000000 1 2 10220006
8 1 10330008 5555aaaa 0 3 1033000b
8 2 10210010 00000000 1 1 10210011
9 0 10310000 11112222 0 1 10310001
9 1 10200000 00000000 1 0 10200000
9 2 30000000 00000000 1 3 30000003

//--- filelist.f
hdl/cluster_periph_pkg.sv
hdl/periph_req_if.sv
hdl/periph_addr_decode.sv
hdl/periph_rr_arbiter.sv
hdl/periph_resp_router.sv
hdl/cluster_periph_xbar.sv
test/tb_clock_gen.sv
test/tb_cluster_periph_xbar.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_cluster_periph_xbar \
  -f filelist.f -o sim_xbar

output=$(./obj_dir/sim_xbar 2>&1 || true)
echo "$output"

if echo "$output" | grep -qx "Test completed successfully"; then
  exit 0
fi
exit 1
